// File: flist.f
+incdir+hw
hw/rv_pkg.sv
hw/rv_ctrl_if.sv
hw/alu.sv
hw/control_fsm.sv
hw/fetch.sv
hw/instruction_decode.sv
hw/top.sv
tests/tb_top.sv

// File: hw/alu.sv
`timescale 1ns/1ps

module alu (
  input  rv_pkg::data_t   a,
  input  rv_pkg::data_t   b,
  input  rv_pkg::alu_op_t op,
  output rv_pkg::data_t   out,
  output logic            zero
);

  always_comb begin
    case (op)
      rv_pkg::alu_add: out = a + b;
      rv_pkg::alu_sub: out = a - b;
      rv_pkg::alu_and: out = a & b;
      rv_pkg::alu_or:  out = a | b;
      // Signed compare.
      rv_pkg::alu_slt: out = ($signed(a) < $signed(b)) ? rv_pkg::data_t'(1) : '0;
      default:         out = a + b;
    endcase
  end

  assign zero = (out == '0);

endmodule

// File: hw/control_fsm.sv
`timescale 1ns/1ps

module control_fsm (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::opcode_t  opcode,
  input  logic [2:0]       funct3,
  input  logic             funct7_5,
  input  logic             zero,
  rv_ctrl_if.ctrl          ctrl
);

  rv_pkg::state_t  state;
  rv_pkg::state_t  state_next;
  rv_pkg::alu_op_t funct_op;
  logic            pc_write;
  logic            branch;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= rv_pkg::s_fetch;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = rv_pkg::s_fetch;
    case (state)
      rv_pkg::s_fetch: state_next = rv_pkg::s_decode;
      rv_pkg::s_decode: begin
        case (opcode)
          rv_pkg::op_load,
          rv_pkg::op_store:  state_next = rv_pkg::s_mem_adr;
          rv_pkg::op_reg,
          rv_pkg::op_imm:    state_next = rv_pkg::s_execute;
          rv_pkg::op_branch: state_next = rv_pkg::s_branch;
          rv_pkg::op_jal:    state_next = rv_pkg::s_jal;
          // Unknown opcode, start over.
          default:           state_next = rv_pkg::s_fetch;
        endcase
      end
      rv_pkg::s_mem_adr: begin
        state_next = (opcode == rv_pkg::op_load) ? rv_pkg::s_mem_read : rv_pkg::s_mem_write;
      end
      rv_pkg::s_mem_read: state_next = rv_pkg::s_mem_wb;
      rv_pkg::s_execute:  state_next = rv_pkg::s_alu_wb;
      rv_pkg::s_jal:      state_next = rv_pkg::s_alu_wb;
      default:            state_next = rv_pkg::s_fetch;
    endcase
  end

  // ALU decoder for R-type and immediate ops.
  always_comb begin
    case (funct3)
      3'b000:  funct_op = (opcode == rv_pkg::op_reg && funct7_5) ? rv_pkg::alu_sub
                                                                 : rv_pkg::alu_add;
      3'b010:  funct_op = rv_pkg::alu_slt;
      3'b110:  funct_op = rv_pkg::alu_or;
      3'b111:  funct_op = rv_pkg::alu_and;
      default: funct_op = rv_pkg::alu_add;
    endcase
  end

  always_comb begin
    ctrl.ir_write   = 1'b0;
    ctrl.reg_write  = 1'b0;
    ctrl.mem_write  = 1'b0;
    ctrl.adr_src    = 1'b0;
    ctrl.pc_src     = rv_pkg::pc_src_result;
    ctrl.alu_src_a  = rv_pkg::src_a_old_pc;
    ctrl.alu_src_b  = rv_pkg::src_b_imm;
    ctrl.alu_op     = rv_pkg::alu_add;
    ctrl.result_src = rv_pkg::res_alu_out;
    pc_write        = 1'b0;
    branch          = 1'b0;
    case (state)
      rv_pkg::s_fetch: begin
        ctrl.ir_write   = 1'b1;
        ctrl.alu_src_a  = rv_pkg::src_a_pc;
        ctrl.alu_src_b  = rv_pkg::src_b_four;
        ctrl.result_src = rv_pkg::res_alu_result;
        pc_write        = 1'b1;
      end
      rv_pkg::s_mem_adr: begin
        ctrl.alu_src_a = rv_pkg::src_a_rs1;
      end
      rv_pkg::s_mem_read: begin
        ctrl.adr_src = 1'b1;
      end
      rv_pkg::s_mem_wb: begin
        ctrl.result_src = rv_pkg::res_mem_data;
        ctrl.reg_write  = 1'b1;
      end
      rv_pkg::s_mem_write: begin
        ctrl.adr_src   = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      rv_pkg::s_execute: begin
        ctrl.alu_src_a = rv_pkg::src_a_rs1;
        ctrl.alu_src_b = (opcode == rv_pkg::op_reg) ? rv_pkg::src_b_rs2 : rv_pkg::src_b_imm;
        ctrl.alu_op    = funct_op;
      end
      rv_pkg::s_alu_wb: begin
        ctrl.reg_write = 1'b1;
      end
      rv_pkg::s_branch: begin
        ctrl.alu_src_a = rv_pkg::src_a_rs1;
        ctrl.alu_src_b = rv_pkg::src_b_rs2;
        ctrl.alu_op    = rv_pkg::alu_sub;
        ctrl.pc_src    = rv_pkg::pc_src_target;
        branch         = 1'b1;
      end
      rv_pkg::s_jal: begin
        // Link value old PC + 4 goes to the ALU output register.
        ctrl.alu_src_b = rv_pkg::src_b_four;
        ctrl.pc_src    = rv_pkg::pc_src_target;
        pc_write       = 1'b1;
      end
      default: begin
      end
    endcase
    ctrl.pc_update = pc_write | (branch & zero);
    // No strobes while in reset.
    if (reset) begin
      ctrl.ir_write  = 1'b0;
      ctrl.reg_write = 1'b0;
      ctrl.mem_write = 1'b0;
      ctrl.pc_update = 1'b0;
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    state inside {[rv_pkg::s_fetch : rv_pkg::s_jal]});

  assert property (@(posedge clk) disable iff (reset)
    !(state == rv_pkg::s_fetch && ctrl.mem_write));

endmodule

// File: hw/fetch.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module fetch (
  input  logic            clk,
  input  logic            reset,
  rv_ctrl_if.dp           ctrl,
  input  rv_pkg::data_t   result,
  input  rv_pkg::data_t   imm_ext,
  input  rv_pkg::data_t   mem_rdata,
  output rv_pkg::data_t   pc,
  output rv_pkg::data_t   old_pc,
  output rv_pkg::instr_t  instr
);

  rv_pkg::data_t target;
  rv_pkg::data_t pc_next;

  // Branch and jump target.
  assign target  = old_pc + imm_ext;
  assign pc_next = (ctrl.pc_src == rv_pkg::pc_src_target) ? target : result;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `RV_RESET_PC;
    end else if (ctrl.pc_update) begin
      pc <= pc_next;
    end
  end

  // Old PC keeps the address of the instruction in the IR.
  always_ff @(posedge clk) begin
    if (ctrl.ir_write) begin
      instr  <= mem_rdata;
      old_pc <= pc;
    end
  end

  assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

// File: hw/instruction_decode.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module instruction_decode (
  input  logic             clk,
  input  logic             reset,
  rv_ctrl_if.dp            ctrl,
  input  rv_pkg::instr_t   instr,
  input  rv_pkg::data_t    result,
  output rv_pkg::opcode_t  opcode,
  output logic [2:0]       funct3,
  output logic             funct7_5,
  output rv_pkg::data_t    rs1_data,
  output rv_pkg::data_t    rs2_data,
  output rv_pkg::data_t    imm_ext
);

  rv_pkg::data_t regs [`RV_NREGS];
  logic [4:0]    rd;

  // Register fields come from the R view.
  assign opcode   = rv_pkg::opcode_t'(instr.r.opcode);
  assign funct3   = instr.r.funct3;
  assign funct7_5 = instr.r.funct7[5];
  assign rd       = instr.r.rd;

  // x0 is never written.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < `RV_NREGS; k++) begin
        regs[k] <= '0;
      end
    end else if (ctrl.reg_write && rd != 5'd0) begin
      regs[rd] <= result;
    end
  end

  always_ff @(posedge clk) begin
    rs1_data <= regs[instr.r.rs1];
    rs2_data <= regs[instr.r.rs2];
  end

  always_comb begin
    case (opcode)
      rv_pkg::op_load,
      rv_pkg::op_imm: begin
        imm_ext = {{(`RV_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
      end
      rv_pkg::op_store: begin
        imm_ext = {{(`RV_XLEN-12){instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
      end
      rv_pkg::op_branch: begin
        imm_ext = {{(`RV_XLEN-12){instr.b.imm_12}}, instr.b.imm_11,
                   instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
      end
      rv_pkg::op_jal: begin
        imm_ext = {{(`RV_XLEN-20){instr.j.imm_20}}, instr.j.imm_19_12,
                   instr.j.imm_11, instr.j.imm_10_1, 1'b0};
      end
      default: imm_ext = '0;
    endcase
  end

endmodule

// File: hw/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Word width, also the address width.
`define RV_XLEN 32

// Size of the register file.
`define RV_NREGS 32

// First instruction address.
`define RV_RESET_PC 32'h0000_0000

`endif

// File: hw/rv_ctrl_if.sv
`timescale 1ns/1ps

interface rv_ctrl_if;

  logic                 ir_write;
  logic                 reg_write;
  logic                 pc_update;
  rv_pkg::pc_src_t      pc_src;
  logic                 adr_src;
  logic                 mem_write;
  rv_pkg::src_a_t       alu_src_a;
  rv_pkg::src_b_t       alu_src_b;
  rv_pkg::alu_op_t      alu_op;
  rv_pkg::result_src_t  result_src;

  modport ctrl (
    output ir_write, reg_write, pc_update, pc_src, adr_src, mem_write,
    output alu_src_a, alu_src_b, alu_op, result_src
  );

  modport dp (
    input ir_write, reg_write, pc_update, pc_src, adr_src, mem_write,
    input alu_src_a, alu_src_b, alu_op, result_src
  );

endinterface

// File: hw/rv_pkg.sv
`include "rv_config.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] data_t;

  typedef enum logic [6:0] {
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_reg    = 7'b0110011,
    op_imm    = 7'b0010011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt
  } alu_op_t;

  // Instruction formats, msb first.
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    j_type_t j;
  } instr_t;

  // The pc encoding feeds the PC increment during fetch.
  typedef enum logic [1:0] {
    src_a_zero,
    src_a_old_pc,
    src_a_rs1,
    src_a_pc
  } src_a_t;

  typedef enum logic [1:0] {
    src_b_rs2,
    src_b_imm,
    src_b_four
  } src_b_t;

  typedef enum logic [1:0] {
    res_alu_out,
    res_mem_data,
    res_alu_result
  } result_src_t;

  typedef enum logic {
    pc_src_result,
    pc_src_target
  } pc_src_t;

  typedef enum logic [3:0] {
    s_fetch,
    s_decode,
    s_mem_adr,
    s_mem_read,
    s_mem_wb,
    s_mem_write,
    s_execute,
    s_alu_wb,
    s_branch,
    s_jal
  } state_t;

endpackage

// File: hw/top.sv
`timescale 1ns/1ps

module top (
  input  logic           clk,
  input  logic           reset,
  output rv_pkg::data_t  mem_addr,
  output rv_pkg::data_t  mem_wdata,
  output logic           mem_we,
  input  rv_pkg::data_t  mem_rdata
);

  rv_pkg::instr_t  instr;
  rv_pkg::opcode_t opcode;
  logic [2:0]      funct3;
  logic            funct7_5;
  logic            zero;
  rv_pkg::data_t   pc;
  rv_pkg::data_t   old_pc;
  rv_pkg::data_t   imm_ext;
  rv_pkg::data_t   rs1_data;
  rv_pkg::data_t   rs2_data;
  rv_pkg::data_t   alu_a;
  rv_pkg::data_t   alu_b;
  rv_pkg::data_t   alu_result;
  rv_pkg::data_t   alu_out;
  rv_pkg::data_t   mem_data;
  rv_pkg::data_t   result;

  rv_ctrl_if ctrl_bus ();

  control_fsm control_fsm_i (
    .clk      (clk),
    .reset    (reset),
    .opcode   (opcode),
    .funct3   (funct3),
    .funct7_5 (funct7_5),
    .zero     (zero),
    .ctrl     (ctrl_bus.ctrl)
  );

  fetch fetch_i (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl_bus.dp),
    .result    (result),
    .imm_ext   (imm_ext),
    .mem_rdata (mem_rdata),
    .pc        (pc),
    .old_pc    (old_pc),
    .instr     (instr)
  );

  instruction_decode instruction_decode_i (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (ctrl_bus.dp),
    .instr    (instr),
    .result   (result),
    .opcode   (opcode),
    .funct3   (funct3),
    .funct7_5 (funct7_5),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm_ext  (imm_ext)
  );

  alu alu_i (
    .a    (alu_a),
    .b    (alu_b),
    .op   (ctrl_bus.alu_op),
    .out  (alu_result),
    .zero (zero)
  );

  always_comb begin
    case (ctrl_bus.alu_src_a)
      rv_pkg::src_a_pc:     alu_a = pc;
      rv_pkg::src_a_old_pc: alu_a = old_pc;
      rv_pkg::src_a_rs1:    alu_a = rs1_data;
      default:              alu_a = '0;
    endcase
  end

  always_comb begin
    case (ctrl_bus.alu_src_b)
      rv_pkg::src_b_rs2:  alu_b = rs2_data;
      rv_pkg::src_b_four: alu_b = rv_pkg::data_t'(4);
      default:            alu_b = imm_ext;
    endcase
  end

  // ALU output and memory data held for the next state.
  always_ff @(posedge clk) begin
    alu_out  <= alu_result;
    mem_data <= mem_rdata;
  end

  always_comb begin
    case (ctrl_bus.result_src)
      rv_pkg::res_mem_data:   result = mem_data;
      rv_pkg::res_alu_result: result = alu_result;
      default:                result = alu_out;
    endcase
  end

  assign mem_addr  = ctrl_bus.adr_src ? result : pc;
  assign mem_wdata = rs2_data;
  assign mem_we    = ctrl_bus.mem_write;

endmodule

// File: tests/tb_top.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module tb_top;

  localparam int RESET_CYCLES = 5;
  localparam int MEM_WORDS    = 256;
  localparam int CPI_MAX      = 5;
  // Instructions over all runs: 5 + 2 x 16 + 13 + 10 + 7.
  localparam int TOTAL_INSTR  = 67;
  localparam int NUM_RUNS     = 6;
  localparam int MAX_CYCLES   = 8 * (TOTAL_INSTR * CPI_MAX + NUM_RUNS * RESET_CYCLES);

  localparam rv_pkg::data_t DATA_BASE = 32'h0000_0200;
  localparam rv_pkg::data_t DONE_ADDR = 32'h0000_03fc;
  localparam rv_pkg::data_t MARKER    = 32'h5a5a_a5a5;

  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_REG    = 7'b0110011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [2:0] F3_ADD     = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_WORD    = 3'b010;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  logic          clk;
  logic          reset;
  rv_pkg::data_t mem_addr;
  rv_pkg::data_t mem_wdata;
  logic          mem_we;
  rv_pkg::data_t mem_rdata;

  rv_pkg::data_t mem [MEM_WORDS];
  rv_pkg::data_t load_addr;
  rv_pkg::data_t first_fetch_addr;
  rv_pkg::data_t first_write_addr;
  logic          first_fetch_seen;
  logic          first_write_seen;
  logic          done_seen;
  int            cycle_count;
  int            test_errors;
  int            error_count;
  int            test_count;
  int            failed_tests;
  int unsigned   first_draw;

  top dut_i (
    .clk       (clk),
    .reset     (reset),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_we    (mem_we),
    .mem_rdata (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Word memory, combinational read.
  assign mem_rdata = mem[mem_addr[9:2]];

  always @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr[9:2]] <= mem_wdata;
    end
    if (!reset && !first_fetch_seen) begin
      first_fetch_addr = mem_addr;
      first_fetch_seen = 1'b1;
    end
    if (!reset && mem_we) begin
      if (!first_write_seen) begin
        first_write_addr = mem_addr;
        first_write_seen = 1'b1;
      end
      if (mem_addr == DONE_ADDR) begin
        done_seen = 1'b1;
      end
    end
  end

  // Watchdog.
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > MAX_CYCLES) begin
      $display("Timeout: the programs did not finish within %0d cycles", MAX_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic rv_pkg::data_t r_format(input logic [6:0] funct7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] funct3,
                                             input logic [4:0] rd);
    return {funct7, rs2, rs1, funct3, rd, OPC_REG};
  endfunction

  function automatic rv_pkg::data_t i_format(input int imm, input logic [4:0] rs1,
                                             input logic [2:0] funct3, input logic [4:0] rd,
                                             input logic [6:0] opcode);
    return {imm[11:0], rs1, funct3, rd, opcode};
  endfunction

  function automatic rv_pkg::data_t s_format(input int imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
  endfunction

  function automatic rv_pkg::data_t b_format(input int imm, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic rv_pkg::data_t j_format(input int imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // Two's complement order from the sign bits, then an unsigned compare.
  function automatic rv_pkg::data_t set_less_than(input rv_pkg::data_t x,
                                                  input rv_pkg::data_t y);
    if (x[`RV_XLEN-1] != y[`RV_XLEN-1]) begin
      return rv_pkg::data_t'(x[`RV_XLEN-1]);
    end
    return (x < y) ? 32'd1 : 32'd0;
  endfunction

  task automatic fill_memory();
    logic [7:0] idx;
    for (int k = 0; k < MEM_WORDS; k++) begin
      idx = k[7:0];
      mem[k] = {idx, ~idx, idx, ~idx};
    end
  endtask

  task automatic poke_word(input rv_pkg::data_t addr, input rv_pkg::data_t value);
    mem[addr[9:2]] = value;
  endtask

  task automatic begin_program();
    load_addr = `RV_RESET_PC;
  endtask

  task automatic put_instr(input rv_pkg::data_t word);
    mem[load_addr[9:2]] = word;
    load_addr = load_addr + 32'd4;
  endtask

  // Done store, then a jump to itself.
  task automatic end_program();
    put_instr(s_format(DONE_ADDR, 0, 0));
    put_instr(j_format(0, 0));
  endtask

  task automatic hold_reset();
    @(negedge clk);
    reset = 1'b1;
  endtask

  task automatic release_reset();
    repeat (RESET_CYCLES) @(negedge clk);
    done_seen        = 1'b0;
    first_fetch_seen = 1'b0;
    first_write_seen = 1'b0;
    reset            = 1'b0;
  endtask

  task automatic run_program();
    while (!done_seen) begin
      @(negedge clk);
    end
  endtask

  task automatic compare_mem_word(input rv_pkg::data_t addr, input rv_pkg::data_t expected,
                                  input string what);
    if (mem[addr[9:2]] !== expected) begin
      $display("mismatch at %0t: %s at 0x%08h is 0x%08h, expected 0x%08h",
               $time, what, addr, mem[addr[9:2]], expected);
      test_errors++;
    end
  endtask

  task automatic expect_bus_addr(input rv_pkg::data_t observed, input rv_pkg::data_t expected,
                                 input string what);
    if (observed !== expected) begin
      $display("mismatch at %0t: %s is 0x%08h, expected 0x%08h",
               $time, what, observed, expected);
      test_errors++;
    end
  endtask

  task automatic report_test(input string name);
    test_count++;
    if (test_errors == 0) begin
      $display("%-32s ok", name);
    end else begin
      $display("%-32s %0d errors", name, test_errors);
      failed_tests++;
      error_count += test_errors;
    end
    test_errors = 0;
  endtask

  task automatic first_fetch_and_no_early_write();
    hold_reset();
    fill_memory();
    begin_program();
    put_instr(i_format(5, 0, F3_ADD, 1, OPC_IMM));
    put_instr(i_format(7, 1, F3_ADD, 2, OPC_IMM));
    put_instr(s_format(DATA_BASE, 2, 0));
    end_program();
    release_reset();
    run_program();
    expect_bus_addr(first_fetch_addr, `RV_RESET_PC, "first fetch address");
    expect_bus_addr(first_write_addr, DATA_BASE, "first write address");
    compare_mem_word(DATA_BASE, 32'd12, "addi chain");
    report_test("first_fetch_and_no_early_write");
  endtask

  task automatic random_reg_ops();
    rv_pkg::data_t a;
    rv_pkg::data_t b;
    a = $urandom();
    b = $urandom();
    hold_reset();
    fill_memory();
    poke_word(DATA_BASE, a);
    poke_word(DATA_BASE + 32'd4, b);
    begin_program();
    put_instr(i_format(DATA_BASE, 0, F3_WORD, 1, OPC_LOAD));
    put_instr(i_format(DATA_BASE + 4, 0, F3_WORD, 2, OPC_LOAD));
    put_instr(r_format(7'b0000000, 2, 1, F3_ADD, 3));
    put_instr(s_format(DATA_BASE + 'h10, 3, 0));
    put_instr(r_format(7'b0100000, 2, 1, F3_ADD, 4));
    put_instr(s_format(DATA_BASE + 'h14, 4, 0));
    put_instr(r_format(7'b0000000, 2, 1, F3_AND, 5));
    put_instr(s_format(DATA_BASE + 'h18, 5, 0));
    put_instr(r_format(7'b0000000, 2, 1, F3_OR, 6));
    put_instr(s_format(DATA_BASE + 'h1c, 6, 0));
    put_instr(r_format(7'b0000000, 2, 1, F3_SLT, 7));
    put_instr(s_format(DATA_BASE + 'h20, 7, 0));
    // Operands swapped for the second compare.
    put_instr(r_format(7'b0000000, 1, 2, F3_SLT, 8));
    put_instr(s_format(DATA_BASE + 'h24, 8, 0));
    end_program();
    release_reset();
    run_program();
    compare_mem_word(DATA_BASE + 'h10, a + b, "add");
    compare_mem_word(DATA_BASE + 'h14, a - b, "sub");
    compare_mem_word(DATA_BASE + 'h18, a & b, "and");
    compare_mem_word(DATA_BASE + 'h1c, a | b, "or");
    compare_mem_word(DATA_BASE + 'h20, set_less_than(a, b), "slt a b");
    compare_mem_word(DATA_BASE + 'h24, set_less_than(b, a), "slt b a");
    report_test("random_reg_ops");
  endtask

  task automatic immediate_ops();
    rv_pkg::data_t v;
    v = $urandom();
    hold_reset();
    fill_memory();
    poke_word(DATA_BASE, v);
    poke_word(DATA_BASE + 'h1c, MARKER);
    begin_program();
    put_instr(i_format(DATA_BASE, 0, F3_WORD, 1, OPC_LOAD));
    put_instr(i_format(-5, 1, F3_ADD, 2, OPC_IMM));
    put_instr(s_format(DATA_BASE + 'h10, 2, 0));
    put_instr(i_format(-16, 1, F3_AND, 3, OPC_IMM));
    put_instr(s_format(DATA_BASE + 'h14, 3, 0));
    put_instr(i_format(-2048, 1, F3_OR, 4, OPC_IMM));
    put_instr(s_format(DATA_BASE + 'h18, 4, 0));
    put_instr(i_format(123, 1, F3_ADD, 0, OPC_IMM));
    put_instr(s_format(DATA_BASE + 'h1c, 0, 0));
    put_instr(i_format(-1, 0, F3_ADD, 5, OPC_IMM));
    put_instr(s_format(DATA_BASE + 'h20, 5, 0));
    end_program();
    release_reset();
    run_program();
    compare_mem_word(DATA_BASE + 'h10, v + 32'hffff_fffb, "addi -5");
    compare_mem_word(DATA_BASE + 'h14, v & 32'hffff_fff0, "andi -16");
    compare_mem_word(DATA_BASE + 'h18, v | 32'hffff_f800, "ori -2048");
    compare_mem_word(DATA_BASE + 'h1c, 32'd0, "x0 after write");
    compare_mem_word(DATA_BASE + 'h20, 32'hffff_ffff, "addi -1 from x0");
    report_test("immediate_ops");
  endtask

  task automatic beq_paths();
    hold_reset();
    fill_memory();
    poke_word(DATA_BASE, MARKER);
    poke_word(DATA_BASE + 32'd4, MARKER);
    begin_program();
    put_instr(i_format(9, 0, F3_ADD, 1, OPC_IMM));
    put_instr(i_format(9, 0, F3_ADD, 2, OPC_IMM));
    put_instr(i_format(4, 0, F3_ADD, 3, OPC_IMM));
    put_instr(i_format('h55, 0, F3_ADD, 4, OPC_IMM));
    put_instr(b_format(8, 1, 2));
    put_instr(s_format(DATA_BASE, 4, 0));
    put_instr(b_format(8, 1, 3));
    put_instr(s_format(DATA_BASE + 4, 4, 0));
    end_program();
    release_reset();
    run_program();
    compare_mem_word(DATA_BASE, MARKER, "store skipped by taken beq");
    compare_mem_word(DATA_BASE + 32'd4, 32'h55, "store after beq not taken");
    report_test("beq_paths");
  endtask

  task automatic jal_link();
    rv_pkg::data_t jal_addr;
    hold_reset();
    fill_memory();
    poke_word(DATA_BASE + 32'd4, MARKER);
    poke_word(DATA_BASE + 32'd8, MARKER);
    begin_program();
    put_instr(i_format(1, 0, F3_ADD, 1, OPC_IMM));
    jal_addr = load_addr;
    put_instr(j_format(12, 5));
    put_instr(s_format(DATA_BASE + 4, 1, 0));
    put_instr(s_format(DATA_BASE + 8, 1, 0));
    put_instr(s_format(DATA_BASE, 5, 0));
    end_program();
    release_reset();
    run_program();
    compare_mem_word(DATA_BASE, jal_addr + 32'd4, "jal link value");
    compare_mem_word(DATA_BASE + 32'd4, MARKER, "first skipped store");
    compare_mem_word(DATA_BASE + 32'd8, MARKER, "second skipped store");
    report_test("jal_link");
  endtask

  initial begin
    reset            = 1'b1;
    done_seen        = 1'b0;
    first_fetch_seen = 1'b0;
    first_write_seen = 1'b0;
    cycle_count      = 0;
    test_errors      = 0;
    error_count      = 0;
    test_count       = 0;
    failed_tests     = 0;
    first_draw       = $urandom(32'he6c001dc);
    fill_memory();
    first_fetch_and_no_early_write();
    random_reg_ops();
    random_reg_ops();
    immediate_ops();
    beq_paths();
    jal_link();
    $display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
